// File: logic/mips_isa_pkg.sv
// MIPS ISA package with instruction field positions, opcodes and data widths
`default_nettype none

package mips_isa_pkg;

  // machine word, also used for byte addresses
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;
  localparam int unsigned reg_count = 32;

  // I-type fields
  typedef logic [5:0] opcode_t;
  typedef logic signed [15:0] imm_t;

  localparam int unsigned opcode_lsb = 26;
  localparam int unsigned rs_lsb     = 21;
  localparam int unsigned rt_lsb     = 16;

  // memory opcodes
  localparam opcode_t op_lw = 6'b100011;
  localparam opcode_t op_sw = 6'b101011;
  localparam opcode_t op_sb = 6'b101000;
  localparam opcode_t op_sh = 6'b101001;

  // data RAM word index, 256 words
  localparam int unsigned ram_addr_w = 8;
  typedef logic [ram_addr_w-1:0] ram_index_t;

endpackage

`default_nettype wire

// File: logic/store_seq_pkg.sv
// store sequencer package with FSM state and lane merge mode types
`default_nettype none

package store_seq_pkg;

  // one state per step of each memory sequence
  typedef enum logic [2:0] {
    idle       = 3'd0,
    word_write = 3'd1,  // sw
    load_read  = 3'd2,  // lw, RAM read in flight
    load_done  = 3'd3,  // lw, data on load_data
    rmw_read   = 3'd4,  // sb/sh, fetch old word
    rmw_merge  = 3'd5,  // sb/sh, register merged word
    rmw_write  = 3'd6   // sb/sh, write merged word back
  } seq_state_t;

  // width of the lane replaced by a partial store
  typedef enum logic [1:0] {
    merge_byte = 2'd0,
    merge_half = 2'd1
  } merge_mode_t;

endpackage

`default_nettype wire

// File: logic/regfile.sv
// register file, 32 by 32 with two combinational reads and one clocked write
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    we,
  input  mips_isa_pkg::reg_addr_t wa,
  input  mips_isa_pkg::reg_addr_t ra1,
  input  mips_isa_pkg::reg_addr_t ra2,
  input  mips_isa_pkg::word_t     wd,
  output mips_isa_pkg::word_t     rd1,
  output mips_isa_pkg::word_t     rd2
);
  import mips_isa_pkg::*;

  word_t rf [reg_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        rf[i] <= '0;
      end
    end else if (we) begin
      rf[wa] <= wd;  // index 0 may be written, it is masked on read
    end
  end

  // r0 is hardwired to zero
  assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
  assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

endmodule

`default_nettype wire

// File: logic/sb_sh_scheduler.sv
// memory op scheduler, decodes lw/sw/sb/sh and steps them through the RAM
`timescale 1ns/1ps
`default_nettype none

module sb_sh_scheduler (
  input  logic                       clk,
  input  logic                       reset,
  input  mips_isa_pkg::word_t        instr,
  input  logic                       instr_valid,
  output mips_isa_pkg::reg_addr_t    ra1,
  output mips_isa_pkg::reg_addr_t    ra2,
  output mips_isa_pkg::imm_t         offset,
  output store_seq_pkg::merge_mode_t mode,
  output logic                       ram_we,
  output logic                       merge_load,
  output logic                       stall,
  output logic                       load_valid
);
  import mips_isa_pkg::*;
  import store_seq_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  opcode_t    opcode;
  logic       accept;

  assign opcode = instr[opcode_lsb +: $bits(opcode_t)];

  // next state and acceptance
  always_comb begin
    state_next = state;
    accept     = 1'b0;
    case (state)
      idle: begin
        if (instr_valid) begin
          accept = 1'b1;
          case (opcode)
            op_sw:        state_next = word_write;
            op_lw:        state_next = load_read;
            op_sb, op_sh: state_next = rmw_read;
            default:      accept = 1'b0;  // not a memory op, dropped
          endcase
        end
      end
      word_write: state_next = idle;
      load_read:  state_next = load_done;
      load_done:  state_next = idle;
      rmw_read:   state_next = rmw_merge;
      rmw_merge:  state_next = rmw_write;
      rmw_write:  state_next = idle;
      default:    state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // operand fields held for the whole sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      ra1    <= instr[rs_lsb +: $bits(reg_addr_t)];  // base
      ra2    <= instr[rt_lsb +: $bits(reg_addr_t)];  // store data
      offset <= instr[$bits(imm_t)-1:0];
      mode   <= (opcode == op_sh) ? merge_half : merge_byte;
    end
  end

  assign stall      = (state != idle);
  assign ram_we     = (state == word_write) || (state == rmw_write);
  assign merge_load = (state == rmw_merge);
  assign load_valid = (state == load_done);

endmodule

`default_nettype wire

// File: logic/byte_merge.sv
// effective address adder and byte/halfword lane merge for partial stores
`timescale 1ns/1ps
`default_nettype none

module byte_merge (
  input  logic                       clk,
  input  logic                       reset,
  input  mips_isa_pkg::word_t        base,
  input  mips_isa_pkg::word_t        store_data,
  input  mips_isa_pkg::word_t        ram_rdata,
  input  mips_isa_pkg::imm_t         offset,
  input  store_seq_pkg::merge_mode_t mode,
  input  logic                       merge_load,
  input  logic                       ram_we,
  output mips_isa_pkg::ram_index_t   ram_index,
  output mips_isa_pkg::word_t        ram_wdata
);
  import mips_isa_pkg::*;
  import store_seq_pkg::*;

  word_t eff_addr;
  word_t merged_next;
  word_t merged_q;
  logic  merge_pending;

  assign eff_addr  = base + {{16{offset[15]}}, offset};
  assign ram_index = eff_addr[ram_addr_w+1:2];  // byte address to word index

  // little-endian lane replace
  always_comb begin
    merged_next = ram_rdata;
    case (mode)
      merge_byte: merged_next[{eff_addr[1:0], 3'b000} +: 8] = store_data[7:0];
      merge_half: merged_next[{eff_addr[1], 4'b0000} +: 16] = store_data[15:0];
      default:    merged_next = ram_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (merge_load) begin
      merged_q <= merged_next;
    end
  end

  // set between the merge and the write back of a sb/sh
  always_ff @(posedge clk) begin
    if (reset) begin
      merge_pending <= 1'b0;
    end else if (merge_load) begin
      merge_pending <= 1'b1;
    end else if (ram_we) begin
      merge_pending <= 1'b0;
    end
  end

  assign ram_wdata = merge_pending ? merged_q : store_data;  // sw passes rt straight

endmodule

`default_nettype wire

// File: logic/data_ram.sv
// data memory, 256 words with clocked write and registered read
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic                     clk,
  input  logic                     we,
  input  mips_isa_pkg::ram_index_t index,
  input  mips_isa_pkg::word_t      wdata,
  output mips_isa_pkg::word_t      rdata
);
  import mips_isa_pkg::*;

  word_t mem [2**ram_addr_w];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
    rdata <= mem[index];  // old word on a same-cycle write
  end

endmodule

`default_nettype wire

// File: logic/store_unit_top.sv
// store unit top, scheduler and register file feeding the merge unit and data RAM
`timescale 1ns/1ps
`default_nettype none

module store_unit_top (
  input  logic                    clk,
  input  logic                    reset,
  input  mips_isa_pkg::word_t     instr,
  input  logic                    instr_valid,
  input  logic                    reg_we,
  input  mips_isa_pkg::reg_addr_t reg_wa,
  input  mips_isa_pkg::word_t     reg_wd,
  output logic                    stall,
  output mips_isa_pkg::word_t     load_data,
  output logic                    load_valid
);
  import mips_isa_pkg::*;
  import store_seq_pkg::*;

  reg_addr_t   ra1;
  reg_addr_t   ra2;
  word_t       rd1;         // base
  word_t       rd2;         // store data
  imm_t        offset;
  merge_mode_t mode;
  logic        ram_we;
  logic        merge_load;
  ram_index_t  ram_index;
  word_t       ram_wdata;
  word_t       ram_rdata;

  sb_sh_scheduler sched_i (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .ra1         (ra1),
    .ra2         (ra2),
    .offset      (offset),
    .mode        (mode),
    .ram_we      (ram_we),
    .merge_load  (merge_load),
    .stall       (stall),
    .load_valid  (load_valid)
  );

  // write port belongs to the outside
  regfile rf_i (
    .clk   (clk),
    .reset (reset),
    .we    (reg_we),
    .wa    (reg_wa),
    .ra1   (ra1),
    .ra2   (ra2),
    .wd    (reg_wd),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  byte_merge merge_i (
    .clk        (clk),
    .reset      (reset),
    .base       (rd1),
    .store_data (rd2),
    .ram_rdata  (ram_rdata),
    .offset     (offset),
    .mode       (mode),
    .merge_load (merge_load),
    .ram_we     (ram_we),
    .ram_index  (ram_index),
    .ram_wdata  (ram_wdata)
  );

  data_ram ram_i (
    .clk   (clk),
    .we    (ram_we),
    .index (ram_index),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  assign load_data = ram_rdata;

endmodule

`default_nettype wire

// File: test/store_unit_tb.sv
// store unit testbench, runs lw/sw/sb/sh against a register and memory model
`timescale 1ns/1ps
`default_nettype none

module store_unit_tb;
  import mips_isa_pkg::*;

  localparam int clk_period = 10;
  localparam int num_sw     = 20;
  localparam int num_part   = 12;  // per partial store kind
  // instructions plus register writes over the whole run
  localparam int num_ops    = 48 + 3 * num_sw + 4 * num_part;

  logic       clk;
  logic       reset;
  word_t      instr;
  logic       instr_valid;
  logic       reg_we;
  reg_addr_t  reg_wa;
  word_t      reg_wd;
  logic       stall;
  word_t      load_data;
  logic       load_valid;

  word_t       regs_m [32];
  word_t       mem_m [256];
  ram_index_t  written [$];  // words that hold known data
  logic [31:0] lfsr_q = 32'h65dd_8c62;
  int          errors = 0;
  int          checks = 0;

  store_unit_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(clk_period * (num_ops * 6 + 100));
    $display("timeout: the run did not finish in the expected time");
    $display("TB FAILED");
    $finish;
  end

  // galois lfsr, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word_t reg_value(input reg_addr_t r);
    return (r == '0) ? 32'h0 : regs_m[r];  // r0 reads zero
  endfunction

  function automatic word_t eff_addr(input reg_addr_t rs, input imm_t imm);
    return reg_value(rs) + word_t'(int'(imm));  // signed offset
  endfunction

  // offset that puts rs + offset on the given low 10 address bits
  function automatic imm_t offset_to(input reg_addr_t rs, input logic [9:0] target);
    word_t b;
    word_t hi;
    b = reg_value(rs);
    hi = rand_bits(6);  // upper offset bits are free
    return {hi[5:0], target - b[9:0]};
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_addr_t r, input word_t v);
    @(negedge clk);
    reg_we = 1'b1;
    reg_wa = r;
    reg_wd = v;
    regs_m[r] = v;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  // one instruction, its stall window, then the model update
  task automatic issue(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                       input imm_t imm, input logic junk);
    word_t ea;
    word_t w;
    word_t d;
    int    exp_len;
    int    len;
    int    pulse_at;
    ea = eff_addr(rs, imm);
    d = reg_value(rt);
    @(negedge clk);
    instr = {op, rs, rt, imm};
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    len = 0;
    pulse_at = -1;
    while (stall && len < 8) begin
      if (load_valid) begin
        pulse_at = len;
        check_word("load_data", mem_m[ea[9:2]], load_data);
      end
      if (junk) begin
        instr = {op_sw, 5'd0, 5'd31, 16'h0000};  // would hit word 0
        instr_valid = 1'b1;
      end
      len++;
      @(negedge clk);
      instr_valid = 1'b0;
    end
    case (op)
      op_sw:        exp_len = 1;
      op_lw:        exp_len = 2;
      op_sb, op_sh: exp_len = 3;
      default:      exp_len = 0;
    endcase
    check_word("stall cycles", exp_len, len);
    checks++;
    assert (pulse_at == ((op == op_lw) ? 1 : -1)) else begin
      $display("Fail at %0t: load_valid cycle expected %0d, got %0d", $time,
               (op == op_lw) ? 1 : -1, pulse_at);
      errors++;
    end
    w = mem_m[ea[9:2]];
    case (op)
      op_sw:   w = d;
      op_sb:   w = (w & ~(32'hff << (8 * ea[1:0]))) | ((d & 32'hff) << (8 * ea[1:0]));
      op_sh:   w = (w & ~(32'hffff << (16 * ea[1]))) | ((d & 32'hffff) << (16 * ea[1]));
      default: ;
    endcase
    mem_m[ea[9:2]] = w;
  endtask

  task automatic load_word(input ram_index_t idx, input logic junk);
    reg_addr_t rs;
    rs = reg_addr_t'(rand_bits(5));
    issue(op_lw, rs, reg_addr_t'(rand_bits(5)), offset_to(rs, {idx, 2'(rand_bits(2))}),
          junk);
  endtask

  // sb or sh into a known word, then read it back
  task automatic partial_store(input opcode_t op);
    ram_index_t idx;
    reg_addr_t  rs;
    int         k;
    k = int'(rand_bits(16) % written.size());
    idx = written[k];
    rs = reg_addr_t'(rand_bits(5));
    issue(op, rs, reg_addr_t'(rand_bits(5)), offset_to(rs, {idx, 2'(rand_bits(2))}),
          rand_bits(1) != 0);
    load_word(idx, 1'b0);
  endtask

  initial begin
    word_t     ea;
    reg_addr_t rs;
    imm_t      imm;
    instr       = '0;
    instr_valid = 1'b0;
    reg_we      = 1'b0;
    reg_wa      = '0;
    reg_wd      = '0;
    reset       = 1'b1;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (4) begin
      @(negedge clk);
      check_word("stall", 0, word_t'(stall));
      check_word("load_valid", 0, word_t'(load_valid));
    end
    reset = 1'b0;
    @(negedge clk);
    check_word("stall", 0, word_t'(stall));
    check_word("load_valid", 0, word_t'(load_valid));

    // registers read zero right after reset
    issue(op_sw, 5'd0, 5'd7, 16'h0100, 1'b0);
    written.push_back(8'h40);
    load_word(8'h40, 1'b0);

    for (int i = 1; i < 32; i++) begin
      write_reg(reg_addr_t'(i), rand_bits(32));
    end
    issue(op_sw, 5'd0, 5'd1, 16'h0000, 1'b0);  // word 0, target of dropped instrs
    written.push_back(8'h00);

    for (int i = 0; i < num_sw; i++) begin
      rs = reg_addr_t'(rand_bits(5));
      imm = imm_t'(rand_bits(16));
      ea = eff_addr(rs, imm);
      written.push_back(ea[9:2]);
      issue(op_sw, rs, reg_addr_t'(rand_bits(5)), imm, 1'b0);
    end
    foreach (written[j]) begin
      load_word(written[j], 1'b1);
    end

    for (int i = 0; i < num_part; i++) begin
      partial_store(op_sb);
    end
    for (int i = 0; i < num_part; i++) begin
      partial_store(op_sh);
    end

    // r0 stays zero as data and as base
    issue(op_sw, 5'd0, 5'd3, 16'h0204, 1'b0);
    written.push_back(8'h81);
    write_reg(5'd0, 32'hdead_beef);
    issue(op_sw, 5'd0, 5'd0, 16'h0204, 1'b0);
    issue(op_lw, 5'd0, 5'd4, 16'h0204, 1'b0);

    // not memory ops, no stall
    issue(6'b001000, 5'd0, 5'd2, 16'h0000, 1'b0);
    issue(6'b100000, 5'd0, 5'd2, 16'h0000, 1'b0);  // lb, unsupported

    foreach (written[j]) begin
      load_word(written[j], 1'b0);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: store_unit.f
logic/mips_isa_pkg.sv
logic/store_seq_pkg.sv
logic/regfile.sv
logic/sb_sh_scheduler.sv
logic/byte_merge.sv
logic/data_ram.sv
logic/store_unit_top.sv
test/store_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := store_unit_tb
FILELIST  := store_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
